//--- hw/div_pkg.sv
/*
 * Divide unit package.
 * Operand width, RISC-V divide operation codes and the structs
 * passed between the issue block, the radix-4 core and the
 * result block.
 */
package div_pkg;

    localparam int XLEN      = 32;
    localparam int DIV_STEPS = XLEN / 2; // Two quotient bits per step.

    // Encoding follows the low two bits of the RISC-V funct3 field.
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    // Request as seen at the unit boundary.
    typedef struct packed {
        div_op_t          op;
        logic [XLEN-1:0]  dividend;
        logic [XLEN-1:0]  divisor;
    } div_req_t;

    // Operand magnitudes handed to the unsigned core.
    typedef struct packed {
        logic [XLEN-1:0]  dividend;
        logic [XLEN-1:0]  divisor;
    } div_core_req_t;

    // Unsigned core result.
    typedef struct packed {
        logic [XLEN-1:0]  quotient;
        logic [XLEN-1:0]  remainder;
        logic             divisor_is_zero;
    } div_core_rsp_t;

    // Sign and selection fixups recorded when a request is accepted.
    typedef struct packed {
        logic is_rem;
        logic negate_quotient;
        logic negate_remainder;
    } div_fix_t;

endpackage

//--- hw/div_issue.sv
/*
 * Divide issue block.
 * Takes one request at a time, records the sign and selection
 * fixups, converts signed operands to magnitudes and starts the
 * unsigned core. Ready stays low until the core reports done.
 */
`timescale 1ns/10ps

module div_issue import div_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  div_req_t      req,
    input  logic          req_valid,
    input  logic          core_done,
    output logic          ready,
    output logic          core_start,
    output div_core_req_t core_req,
    output div_fix_t      fix
);

    logic busy;
    logic accept;
    logic is_signed;
    logic dividend_neg;
    logic divisor_neg;

    assign accept    = req_valid & ~busy;
    assign is_signed = (req.op == DIV) || (req.op == REM);

    // Operand signs only count for the signed operations.
    assign dividend_neg = is_signed & req.dividend[XLEN-1];
    assign divisor_neg  = is_signed & req.divisor[XLEN-1];

    assign ready = ~busy;

    // One division in flight at most.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (core_done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            core_start <= 1'b0;
        end else begin
            core_start <= accept; // Single cycle, one after acceptance.
        end
    end

    // Magnitudes and fixups, held until the next acceptance.
    always_ff @(posedge clk) begin
        if (accept) begin
            core_req.dividend    <= dividend_neg ? -req.dividend : req.dividend;
            core_req.divisor     <= divisor_neg ? -req.divisor : req.divisor;
            fix.is_rem           <= (req.op == REM) || (req.op == REMU);
            fix.negate_quotient  <= dividend_neg ^ divisor_neg;
            fix.negate_remainder <= dividend_neg; // Remainder takes the dividend's sign.
        end
    end

    // The core must have finished before a new start reaches it.
    core_start_not_at_done: assert property (
        @(posedge clk) disable iff (rst)
        core_start |-> !core_done
    );

endmodule

//--- hw/div_radix4_core.sv
/*
 * Unsigned radix-4 restoring divider.
 * Retires two quotient bits per cycle by trying 1x, 2x and 3x the
 * divisor in parallel. Ends at once when the divisor exceeds the
 * dividend. Start is a one-cycle level, done a one-cycle pulse.
 */
`timescale 1ns/10ps

module div_radix4_core import div_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  div_core_req_t req,
    output logic          done,
    output div_core_rsp_t rsp
);

    logic                 terminate;       // High while no division is running.
    logic                 terminate_early;
    logic [DIV_STEPS-1:0] shift_count;

    logic [XLEN+1:0]      pr;              // Partial remainder, two guard bits.
    logic [XLEN-1:0]      quotient;
    logic                 divisor_is_zero;

    logic [XLEN+1:0]      b_1;
    logic [XLEN+1:0]      b_2;
    logic [XLEN+1:0]      b_3;
    logic [XLEN+2:0]      new_pr_1;
    logic [XLEN+2:0]      new_pr_2;
    logic [XLEN+2:0]      new_pr_3;
    logic [2:0]           new_pr_sign;

    // Trial subtractions, the top bit is the borrow.
    assign new_pr_1 = {1'b0, pr} - {1'b0, b_1};
    assign new_pr_2 = {1'b0, pr} - {1'b0, b_2};
    assign new_pr_3 = {1'b0, pr} - {1'b0, b_3};
    assign new_pr_sign = {new_pr_3[XLEN+2], new_pr_2[XLEN+2], new_pr_1[XLEN+2]};

    assign terminate_early = req.divisor > req.dividend;

    // Step counter, one bit walks through per iteration.
    always_ff @(posedge clk) begin
        if (rst) begin
            shift_count <= '0;
        end else begin
            shift_count <= {shift_count[DIV_STEPS-2:0], start & ~terminate_early};
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (terminate_early) begin
                pr       <= {req.dividend, 2'b00}; // Remainder is the dividend.
                quotient <= '0;
            end else begin
                pr       <= {{XLEN{1'b0}}, req.dividend[XLEN-1:XLEN-2]};
                quotient <= {req.dividend[XLEN-3:0], 2'b00};
            end
            b_1 <= {2'b00, req.divisor};
            b_2 <= {1'b0, req.divisor, 1'b0};
            b_3 <= {1'b0, req.divisor, 1'b0} + {2'b00, req.divisor};
        end else if (~terminate) begin
            // Quotient register also holds the unused dividend bits.
            case (new_pr_sign)
                3'b111: begin // Digit 0.
                    pr       <= {pr[XLEN-1:0], quotient[XLEN-1:XLEN-2]};
                    quotient <= {quotient[XLEN-3:0], 2'b00};
                end
                3'b110: begin // Digit 1.
                    pr       <= {new_pr_1[XLEN-1:0], quotient[XLEN-1:XLEN-2]};
                    quotient <= {quotient[XLEN-3:0], 2'b01};
                end
                3'b100: begin // Digit 2.
                    pr       <= {new_pr_2[XLEN-1:0], quotient[XLEN-1:XLEN-2]};
                    quotient <= {quotient[XLEN-3:0], 2'b10};
                end
                default: begin // Digit 3, no borrow at all.
                    pr       <= {new_pr_3[XLEN-1:0], quotient[XLEN-1:XLEN-2]};
                    quotient <= {quotient[XLEN-3:0], 2'b11};
                end
            endcase
        end
    end

    /*
     * A zero divisor never borrows, so every digit is 3. The only
     * nonzero divisor that does the same is 1, which is odd.
     */
    always_ff @(posedge clk) begin
        if (start) begin
            divisor_is_zero <= ~req.divisor[0] & ~terminate_early;
        end else if (~terminate) begin
            divisor_is_zero <= divisor_is_zero & ~(|new_pr_sign);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            terminate <= 1'b1;
        end else if (start) begin
            terminate <= terminate_early;
        end else if (shift_count[DIV_STEPS-1]) begin
            terminate <= 1'b1; // Last step retires this cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= (~start & shift_count[DIV_STEPS-1]) | (start & terminate_early);
        end
    end

    assign rsp.quotient        = quotient;
    assign rsp.remainder       = pr[XLEN+1:2];
    assign rsp.divisor_is_zero = divisor_is_zero;

    done_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    );

    // A new start must wait until the previous division has ended.
    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> terminate
    );

endmodule

//--- hw/div_result_sel.sv
/*
 * Divide result block.
 * Restores the operand signs on the core's magnitudes, keeps the
 * all-ones quotient for division by zero, picks quotient or
 * remainder and registers it with the result pulse.
 */
`timescale 1ns/10ps

module div_result_sel import div_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            core_done,
    input  div_core_rsp_t   core_rsp,
    input  div_fix_t        fix,
    output logic [XLEN-1:0] result,
    output logic            result_valid
);

    logic            negate_quotient;
    logic [XLEN-1:0] quotient_signed;
    logic [XLEN-1:0] remainder_signed;

    // Quotient of a zero divisor stays -1 whatever the dividend sign.
    assign negate_quotient = fix.negate_quotient & ~core_rsp.divisor_is_zero;

    assign quotient_signed = negate_quotient ? -core_rsp.quotient : core_rsp.quotient;

    // For a zero divisor this gives back the original dividend.
    assign remainder_signed = fix.negate_remainder ? -core_rsp.remainder
                                                   : core_rsp.remainder;

    /*
     * Overflow of the most negative value by -1 falls out of the
     * magnitude path: 2^31 / 1 with equal signs reads as the dividend.
     */
    always_ff @(posedge clk) begin
        if (core_done) begin
            result <= fix.is_rem ? remainder_signed : quotient_signed;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= core_done; // One cycle after the core.
        end
    end

endmodule

//--- hw/div_unit.sv
/*
 * 32-bit integer divide unit for DIV, DIVU, REM and REMU.
 * Issue block, unsigned radix-4 core and result block in a row.
 * One request in flight, results come out in order as pulses.
 */
`timescale 1ns/10ps

module div_unit import div_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  div_req_t        req,
    input  logic            req_valid,
    output logic            ready,
    output logic [XLEN-1:0] result,
    output logic            result_valid
);

    logic          core_start;
    logic          core_done;
    div_core_req_t core_req;
    div_core_rsp_t core_rsp;
    div_fix_t      fix;

    div_issue issue0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .core_done  (core_done),
        .ready      (ready),
        .core_start (core_start),
        .core_req   (core_req),
        .fix        (fix)
    );

    div_radix4_core core0 (
        .clk   (clk),
        .rst   (rst),
        .start (core_start),
        .req   (core_req),
        .done  (core_done),
        .rsp   (core_rsp)
    );

    div_result_sel result0 (
        .clk          (clk),
        .rst          (rst),
        .core_done    (core_done),
        .core_rsp     (core_rsp),
        .fix          (fix),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- testbench/tb_div_unit.sv
/*
 * Testbench for the divide unit.
 * Issues DIV, DIVU, REM and REMU requests back to back, checks each
 * result pulse against a RISC-V reference model and counts errors.
 */
`timescale 1ns/10ps

module tb_div_unit import div_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_RANDOM   = 48; // Requests per random group.
    localparam int NUM_DIRECTED = 21;
    localparam int NUM_TESTS    = 2 * NUM_RANDOM + NUM_DIRECTED;
    localparam int WATCHDOG_NS  = NUM_TESTS * (DIV_STEPS + 6) * CLK_PERIOD + 2000;

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] ALL_ONES = '1;

    logic            clk;
    logic            rst;
    div_req_t        req;
    logic            req_valid;
    logic            ready;
    logic [XLEN-1:0] result;
    logic            result_valid;

    logic [31:0]     lfsr_state;
    logic [XLEN-1:0] expected_q[$]; // Expected results in issue order.
    string           desc_q[$];
    int              issued_count;
    int              result_count;
    int              check_count;
    int              mismatch_count;
    int              other_error_count;

    div_unit dut0 (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .ready        (ready),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_bits(input int count, output logic [XLEN-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit.
            value      = {value[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // RISC-V M extension rules for the four divide operations.
    function automatic logic [XLEN-1:0] expected_result(input div_op_t op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic            is_signed;
        logic            is_rem;
        logic [XLEN-1:0] value;
        is_signed = (op == DIV) || (op == REM);
        is_rem    = (op == REM) || (op == REMU);
        if (b == '0) begin
            value = is_rem ? a : ALL_ONES;
        end else if (is_signed && (a == MOST_NEG) && (b == ALL_ONES)) begin
            value = is_rem ? '0 : MOST_NEG; // Overflow keeps the dividend.
        end else if (is_signed) begin
            // Truncates toward zero, remainder takes the dividend's sign.
            if (is_rem) begin
                value = $signed(a) % $signed(b);
            end else begin
                value = $signed(a) / $signed(b);
            end
        end else begin
            value = is_rem ? (a % b) : (a / b);
        end
        return value;
    endfunction

    task automatic compare_values(input logic [XLEN-1:0] actual,
                                  input logic [XLEN-1:0] expected,
                                  input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s gave %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, other errors %0d, results %0d of %0d",
                 check_count, mismatch_count, other_error_count,
                 result_count, issued_count);
    endtask

    // Waits for ready, then holds req_valid for the accepting edge.
    task automatic issue_request(input div_op_t op,
                                 input logic [XLEN-1:0] a,
                                 input logic [XLEN-1:0] b);
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req       <= '{op: op, dividend: a, divisor: b};
        req_valid <= 1'b1;
        expected_q.push_back(expected_result(op, a, b));
        desc_q.push_back($sformatf("%s %h by %h", op.name(), a, b));
        issued_count++;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic run_directed();
        // Divisor above the dividend ends the core early.
        issue_request(DIVU, 32'd5, 32'd7);
        issue_request(REMU, 32'd5, 32'd7);
        issue_request(DIVU, 32'h7fff_ffff, 32'h8000_0000);
        issue_request(REMU, 32'h7fff_ffff, 32'h8000_0000);
        issue_request(DIV, 32'hffff_fffb, 32'd7);
        issue_request(REM, 32'hffff_fffb, 32'd7);
        // Division by zero.
        issue_request(DIVU, 32'h1234_5678, '0);
        issue_request(DIV, 32'h1234_5678, '0);
        issue_request(DIV, 32'h8765_4321, '0);
        issue_request(REMU, 32'h8765_4321, '0);
        issue_request(REM, 32'h8765_4321, '0);
        issue_request(DIVU, '0, '0);
        // Signed overflow.
        issue_request(DIV, MOST_NEG, ALL_ONES);
        issue_request(REM, MOST_NEG, ALL_ONES);
        // Edge operands.
        issue_request(DIVU, ALL_ONES, 32'd1);
        issue_request(DIV, MOST_NEG, 32'd1);
        issue_request(REM, MOST_NEG, 32'd3);
        issue_request(DIV, 32'd100, 32'hffff_fff9);
        issue_request(DIVU, '0, 32'd5);
        issue_request(DIVU, 32'd1, 32'd1);
        issue_request(REMU, ALL_ONES, ALL_ONES);
    endtask

    // The divisor is scaled down so both core paths show up.
    task automatic run_unsigned_random();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] shift;
        logic [XLEN-1:0] pick;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_bits(XLEN, a);
            random_bits(XLEN, b);
            random_bits(5, shift);
            random_bits(1, pick);
            b = b >> shift;
            issue_request(pick[0] ? REMU : DIVU, a, b);
        end
    endtask

    task automatic run_signed_random();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] shift;
        logic [XLEN-1:0] pick;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_bits(XLEN, a);
            random_bits(XLEN, b);
            random_bits(5, shift);
            random_bits(1, pick);
            b = $signed(b) >>> shift; // Sign survives the scaling.
            issue_request(pick[0] ? REM : DIV, a, b);
        end
    endtask

    // Results are registered, so mid-cycle sampling is stable.
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            result_count++;
            if (expected_q.size() == 0) begin
                other_error_count++;
                $display("error at %0t: result_valid came with no request outstanding",
                         $time);
            end else begin
                compare_values(result, expected_q.pop_front(), desc_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the divide unit stopped returning results",
                 WATCHDOG_NS);
        print_counts();
        $display("sim failed");
        $finish;
    end

    initial begin
        rst               = 1'b1;
        req_valid         = 1'b0;
        req               = '0;
        lfsr_state        = 32'd39;
        issued_count      = 0;
        result_count      = 0;
        check_count       = 0;
        mismatch_count    = 0;
        other_error_count = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        compare_values(XLEN'(ready), XLEN'(1), "ready after reset");
        compare_values(XLEN'(result_valid), XLEN'(0), "result_valid after reset");

        run_directed();
        run_unsigned_random();
        run_signed_random();

        // Let the last division finish, then look for stray pulses.
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (DIV_STEPS + 6) @(negedge clk);
        compare_values(XLEN'(result_count), XLEN'(issued_count), "result count");

        print_counts();
        if (mismatch_count == 0 && other_error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/div_pkg.sv
hw/div_issue.sv
hw/div_radix4_core.sv
hw/div_result_sel.sv
hw/div_unit.sv
testbench/tb_div_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_div_unit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# Pass or fail comes from the pass line in the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
